/* all.f */
exec_pkg.sv
exec_div_if.sv
exec_alu.sv
exec_divider.sv
exec_retire.sv
exec_unit.sv
tb_exec_unit.sv

/* exec_alu.sv */
`timescale 1ns/1ps

module exec_alu
	import exec_pkg::*;
#(
	parameter int DATA_WIDTH = 32
)(
	input exec_op_e op,
	input logic [DATA_WIDTH-1:0] src0,
	input logic [DATA_WIDTH-1:0] src1,
	output logic [DATA_WIDTH-1:0] result,
	output exec_flags_t flags
);

	localparam int SH_W = $clog2(DATA_WIDTH);
	localparam int MSB = DATA_WIDTH - 1;

	logic [SH_W-1:0] shamt;
	logic [DATA_WIDTH:0] sum;
	logic [DATA_WIDTH:0] diff;
	logic [2*DATA_WIDTH-1:0] product;
	logic [2*DATA_WIDTH-1:0] rol_tmp;
	logic [2*DATA_WIDTH-1:0] ror_tmp;
	logic carry;
	logic overflow;

	assign shamt = src1[SH_W-1:0];
	assign sum = {1'b0, src0} + {1'b0, src1};
	assign diff = {1'b0, src0} - {1'b0, src1};
	assign product = src0 * src1;

	// Rotates come out of a doubled copy of the operand
	assign rol_tmp = {src0, src0} << shamt;
	assign ror_tmp = {src0, src0} >> shamt;

	always_comb begin
		result = '0;
		carry = 1'b0;
		overflow = 1'b0;
		case (op)
			AND:  result = src0 & src1;
			OR:   result = src0 | src1;
			XOR:  result = src0 ^ src1;
			NOT:  result = ~src0;
			SHL:  result = src0 << shamt;
			SHR:  result = src0 >> shamt;
			SAR:  result = $signed(src0) >>> shamt;
			ROL:  result = rol_tmp[2*DATA_WIDTH-1:DATA_WIDTH];
			ROR:  result = ror_tmp[DATA_WIDTH-1:0];
			ADD: begin
				result = sum[DATA_WIDTH-1:0];
				carry = sum[DATA_WIDTH];
				overflow = (src0[MSB] == src1[MSB]) && (sum[MSB] != src0[MSB]);
			end
			SUB: begin
				result = diff[DATA_WIDTH-1:0];
				// Borrow out of the top bit
				carry = diff[DATA_WIDTH];
				overflow = (src0[MSB] != src1[MSB]) && (diff[MSB] != src0[MSB]);
			end
			MUL: begin
				result = product[DATA_WIDTH-1:0];
				carry = product[DATA_WIDTH];
				overflow = product[DATA_WIDTH] ^ product[DATA_WIDTH-1];
			end
			MULH: result = product[2*DATA_WIDTH-1:DATA_WIDTH];
			// Divides are handled by the divider
			default: result = '0;
		endcase
	end

	// Order is sign, overflow, carry, parity, zero
	assign flags = {result[MSB], overflow, carry, result[0], ~|result};

endmodule

/* exec_div_if.sv */
`timescale 1ns/1ps

interface exec_div_if
	import exec_pkg::*;
#(
	parameter int DATA_WIDTH = 32
)();

	logic start;
	exec_op_e op;
	logic [DATA_WIDTH-1:0] dividend;
	logic [DATA_WIDTH-1:0] divisor;
	logic flush;
	logic busy;
	logic done;
	logic [DATA_WIDTH-1:0] quotient;
	logic [DATA_WIDTH-1:0] remainder;

	modport ctrl (
		output start, op, dividend, divisor, flush,
		input busy, done, quotient, remainder
	);

	modport div (
		input start, op, dividend, divisor, flush,
		output busy, done, quotient, remainder
	);

endinterface

/* exec_divider.sv */
`timescale 1ns/1ps

module exec_divider
	import exec_pkg::*;
#(
	parameter int DATA_WIDTH = 32
)(
	input logic iCLOCK,
	input logic inRESET,
	exec_div_if.div div
);

	localparam int CNT_W = $clog2(DATA_WIDTH + 1);
	localparam int MSB = DATA_WIDTH - 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(DATA_WIDTH);

	logic signed_op;
	logic [DATA_WIDTH-1:0] dividend_abs;
	logic [DATA_WIDTH-1:0] divisor_abs;
	logic [DATA_WIDTH:0] shifted;
	logic [DATA_WIDTH:0] diff;
	logic busy;
	logic done;
	logic [CNT_W-1:0] count;
	logic neg_q;
	logic neg_r;
	logic [DATA_WIDTH-1:0] q_reg;
	logic [DATA_WIDTH-1:0] r_reg;
	logic [DATA_WIDTH-1:0] d_reg;

	assign signed_op = (div.op == SDIV) || (div.op == SMOD);
	assign dividend_abs = (signed_op && div.dividend[MSB]) ? -div.dividend : div.dividend;
	assign divisor_abs = (signed_op && div.divisor[MSB]) ? -div.divisor : div.divisor;

	// Partial remainder with the next dividend bit shifted in
	assign shifted = {r_reg, q_reg[MSB]};
	assign diff = shifted - {1'b0, d_reg};

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			busy <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else if (div.flush) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (div.start) begin
				busy <= 1'b1;
				count <= '0;
			end else if (busy) begin
				if (count == LAST) begin
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					count <= count + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (div.start) begin
			q_reg <= dividend_abs;
			r_reg <= '0;
			d_reg <= divisor_abs;
			neg_q <= signed_op && (div.dividend[MSB] ^ div.divisor[MSB]);
			neg_r <= signed_op && div.dividend[MSB];
		end else if (busy) begin
			if (count == LAST) begin
				// Truncate toward zero, remainder follows the dividend
				if (neg_q)
					q_reg <= -q_reg;
				if (neg_r)
					r_reg <= -r_reg;
			end else if (!diff[DATA_WIDTH]) begin
				q_reg <= {q_reg[MSB-1:0], 1'b1};
				r_reg <= diff[DATA_WIDTH-1:0];
			end else begin
				q_reg <= {q_reg[MSB-1:0], 1'b0};
				r_reg <= shifted[DATA_WIDTH-1:0];
			end
		end
	end

	assign div.busy = busy;
	assign div.done = done;
	assign div.quotient = q_reg;
	assign div.remainder = r_reg;

	// Retire controller only starts a division on an idle divider
	a_start_idle: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		div.start |-> !busy);

endmodule

/* exec_pkg.sv */
package exec_pkg;

	localparam int REG_ADDR_W = 5;

	// The issued PC already points past the instruction
	localparam int PC_STEP = 4;

	typedef enum logic [4:0] {
		AND  = 5'h00,
		OR   = 5'h01,
		XOR  = 5'h02,
		NOT  = 5'h03,
		SHL  = 5'h04,
		SHR  = 5'h05,
		SAR  = 5'h06,
		ROL  = 5'h07,
		ROR  = 5'h08,
		ADD  = 5'h09,
		SUB  = 5'h0a,
		MUL  = 5'h0b,
		MULH = 5'h0c,
		UDIV = 5'h0d,
		SDIV = 5'h0e,
		UMOD = 5'h0f,
		SMOD = 5'h10
	} exec_op_e;

	typedef struct packed {
		logic sign;
		logic overflow;
		logic carry;
		logic parity;
		logic zero;
	} exec_flags_t;

	typedef enum logic [6:0] {
		FAULT_INVALID_INST = 7'd2,
		FAULT_DIVIDE_ERROR = 7'd3
	} exec_fault_e;

	typedef enum logic [1:0] {
		ST_NORMAL,
		ST_DIV_WAIT,
		ST_FAULT
	} exec_state_e;

	function automatic logic is_div_op(exec_op_e op);
		return op inside {UDIV, SDIV, UMOD, SMOD};
	endfunction

endpackage

/* exec_retire.sv */
`timescale 1ns/1ps

module exec_retire
	import exec_pkg::*;
#(
	parameter int DATA_WIDTH = 32
)(
	input logic iCLOCK,
	input logic inRESET,
	input logic refresh,
	input logic in_valid,
	input exec_op_e in_op,
	input logic in_invalid,
	input logic [DATA_WIDTH-1:0] in_src0,
	input logic [DATA_WIDTH-1:0] in_src1,
	input logic [REG_ADDR_W-1:0] in_dest,
	input logic in_writeback,
	input logic in_flags_writeback,
	input logic [DATA_WIDTH-1:0] in_pc,
	output logic issue_lock,
	input logic [DATA_WIDTH-1:0] alu_result,
	input exec_flags_t alu_flags,
	exec_div_if.ctrl div,
	output logic out_valid,
	output logic [DATA_WIDTH-1:0] out_data,
	output logic [REG_ADDR_W-1:0] out_dest,
	output logic out_writeback,
	output logic [DATA_WIDTH-1:0] out_pc,
	output exec_flags_t flags,
	output logic fault_valid,
	output exec_fault_e fault_num,
	output logic [DATA_WIDTH-1:0] fault_pc
);

	exec_state_e state;
	exec_op_e div_op;
	logic accept;
	logic is_div;
	logic div_zero;

	assign issue_lock = (state != ST_NORMAL);
	assign accept = in_valid && !issue_lock && !refresh;
	assign is_div = is_div_op(in_op);
	assign div_zero = is_div && (in_src1 == '0);

	assign div.start = accept && !in_invalid && is_div && !div_zero;
	assign div.op = in_op;
	assign div.dividend = in_src0;
	assign div.divisor = in_src1;
	assign div.flush = refresh;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_NORMAL;
			out_valid <= 1'b0;
			fault_valid <= 1'b0;
		end else if (refresh) begin
			state <= ST_NORMAL;
			out_valid <= 1'b0;
			fault_valid <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			fault_valid <= 1'b0;
			case (state)
				ST_NORMAL: begin
					if (accept) begin
						// Invalid instruction wins over divide by zero
						if (in_invalid || div_zero) begin
							state <= ST_FAULT;
							fault_valid <= 1'b1;
						end else if (is_div) begin
							state <= ST_DIV_WAIT;
						end else begin
							out_valid <= 1'b1;
						end
					end
				end
				ST_DIV_WAIT: begin
					if (div.done) begin
						state <= ST_NORMAL;
						out_valid <= 1'b1;
					end
				end
				// Held until refresh
				ST_FAULT: state <= ST_FAULT;
				default: state <= ST_NORMAL;
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			out_data <= alu_result;
			out_dest <= in_dest;
			out_writeback <= in_writeback;
			out_pc <= in_pc;
			div_op <= in_op;
			fault_num <= in_invalid ? FAULT_INVALID_INST : FAULT_DIVIDE_ERROR;
			fault_pc <= in_pc - DATA_WIDTH'(PC_STEP);
		end else if (state == ST_DIV_WAIT && div.done) begin
			out_data <= (div_op == UDIV || div_op == SDIV) ? div.quotient : div.remainder;
		end
	end

	// Flags survive a refresh
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET)
			flags <= '0;
		else if (accept && !in_invalid && !is_div && in_flags_writeback)
			flags <= alu_flags;
	end

	a_one_result: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(out_valid && fault_valid));

	// Issuer stays locked out while a division is in flight
	a_lock_held: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		div.busy |-> issue_lock);

endmodule

/* exec_unit.sv */
`timescale 1ns/1ps

module exec_unit
	import exec_pkg::*;
#(
	parameter int DATA_WIDTH = 32
)(
	input logic iCLOCK,
	input logic inRESET,
	input logic refresh,
	input logic in_valid,
	input exec_op_e in_op,
	input logic in_invalid,
	input logic [DATA_WIDTH-1:0] in_src0,
	input logic [DATA_WIDTH-1:0] in_src1,
	input logic [REG_ADDR_W-1:0] in_dest,
	input logic in_writeback,
	input logic in_flags_writeback,
	input logic [DATA_WIDTH-1:0] in_pc,
	output logic issue_lock,
	output logic out_valid,
	output logic [DATA_WIDTH-1:0] out_data,
	output logic [REG_ADDR_W-1:0] out_dest,
	output logic out_writeback,
	output logic [DATA_WIDTH-1:0] out_pc,
	output exec_flags_t flags,
	output logic fault_valid,
	output exec_fault_e fault_num,
	output logic [DATA_WIDTH-1:0] fault_pc
);

	logic [DATA_WIDTH-1:0] alu_result;
	exec_flags_t alu_flags;

	exec_div_if #(.DATA_WIDTH(DATA_WIDTH)) u_div_if ();

	exec_alu #(.DATA_WIDTH(DATA_WIDTH)) u_alu (
		.op     (in_op),
		.src0   (in_src0),
		.src1   (in_src1),
		.result (alu_result),
		.flags  (alu_flags)
	);

	exec_divider #(.DATA_WIDTH(DATA_WIDTH)) u_divider (
		.iCLOCK  (iCLOCK),
		.inRESET (inRESET),
		.div     (u_div_if)
	);

	exec_retire #(.DATA_WIDTH(DATA_WIDTH)) u_retire (
		.iCLOCK             (iCLOCK),
		.inRESET            (inRESET),
		.refresh            (refresh),
		.in_valid           (in_valid),
		.in_op              (in_op),
		.in_invalid         (in_invalid),
		.in_src0            (in_src0),
		.in_src1            (in_src1),
		.in_dest            (in_dest),
		.in_writeback       (in_writeback),
		.in_flags_writeback (in_flags_writeback),
		.in_pc              (in_pc),
		.issue_lock         (issue_lock),
		.alu_result         (alu_result),
		.alu_flags          (alu_flags),
		.div                (u_div_if),
		.out_valid          (out_valid),
		.out_data           (out_data),
		.out_dest           (out_dest),
		.out_writeback      (out_writeback),
		.out_pc             (out_pc),
		.flags              (flags),
		.fault_valid        (fault_valid),
		.fault_num          (fault_num),
		.fault_pc           (fault_pc)
	);

endmodule

/* tb_exec_unit.sv */
`timescale 1ns/1ps

module tb_exec_unit
	import exec_pkg::*;
();

	localparam int DATA_WIDTH = 32;
	localparam int MAX_WAIT = DATA_WIDTH + 10;

	typedef struct {
		string name;
		exec_op_e op;
		logic [DATA_WIDTH-1:0] src0;
		logic [DATA_WIDTH-1:0] src1;
		logic [REG_ADDR_W-1:0] dest;
		logic wb;
		logic flags_wb;
		logic invalid;
	} entry_t;

	logic iCLOCK;
	logic inRESET;
	logic refresh;
	logic in_valid;
	exec_op_e in_op;
	logic in_invalid;
	logic [DATA_WIDTH-1:0] in_src0;
	logic [DATA_WIDTH-1:0] in_src1;
	logic [REG_ADDR_W-1:0] in_dest;
	logic in_writeback;
	logic in_flags_writeback;
	logic [DATA_WIDTH-1:0] in_pc;
	logic issue_lock;
	logic out_valid;
	logic [DATA_WIDTH-1:0] out_data;
	logic [REG_ADDR_W-1:0] out_dest;
	logic out_writeback;
	logic [DATA_WIDTH-1:0] out_pc;
	exec_flags_t flags;
	logic fault_valid;
	exec_fault_e fault_num;
	logic [DATA_WIDTH-1:0] fault_pc;

	entry_t tbl[$];
	exec_flags_t exp_flags;
	logic [31:0] rng_state = 32'd98;
	logic table_ready = 1'b0;
	int mismatches = 0;
	int failures = 0;
	int timeouts = 0;

	exec_unit #(.DATA_WIDTH(DATA_WIDTH)) u_exec_unit (.*);

	always #50 iCLOCK = ~iCLOCK;

	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic divide_op(exec_op_e op);
		return op == UDIV || op == SDIV || op == UMOD || op == SMOD;
	endfunction

	function automatic logic [DATA_WIDTH-1:0] pc_of(int idx);
		return DATA_WIDTH'(32'h100 + 4 * idx);
	endfunction

	function automatic logic [DATA_WIDTH-1:0] expect_result(exec_op_e op,
			logic [DATA_WIDTH-1:0] a, logic [DATA_WIDTH-1:0] b);
		logic [2*DATA_WIDTH-1:0] prod;
		logic [DATA_WIDTH-1:0] fill;
		int sh;
		sh = b % DATA_WIDTH;
		prod = {{DATA_WIDTH{1'b0}}, a} * {{DATA_WIDTH{1'b0}}, b};
		fill = a[DATA_WIDTH-1] ? ~({DATA_WIDTH{1'b1}} >> sh) : '0;
		case (op)
			AND:  return a & b;
			OR:   return a | b;
			XOR:  return a ^ b;
			NOT:  return ~a;
			SHL:  return a << sh;
			SHR:  return a >> sh;
			SAR:  return (a >> sh) | fill;
			ROL:  return (sh == 0) ? a : (a << sh) | (a >> (DATA_WIDTH - sh));
			ROR:  return (sh == 0) ? a : (a >> sh) | (a << (DATA_WIDTH - sh));
			ADD:  return a + b;
			SUB:  return a - b;
			MUL:  return prod[DATA_WIDTH-1:0];
			MULH: return prod[2*DATA_WIDTH-1:DATA_WIDTH];
			UDIV: return a / b;
			UMOD: return a % b;
			SDIV: return $signed(a) / $signed(b);
			SMOD: return $signed(a) % $signed(b);
			default: return '0;
		endcase
	endfunction

	function automatic exec_flags_t expect_flags(exec_op_e op, logic [DATA_WIDTH-1:0] a,
			logic [DATA_WIDTH-1:0] b, logic [DATA_WIDTH-1:0] r);
		exec_flags_t f;
		longint sa;
		longint sb;
		longint smax;
		logic [2*DATA_WIDTH-1:0] prod;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		smax = (longint'(1) << (DATA_WIDTH - 1)) - 1;
		prod = {{DATA_WIDTH{1'b0}}, a} * {{DATA_WIDTH{1'b0}}, b};
		f = '{sign: r[DATA_WIDTH-1], overflow: 1'b0, carry: 1'b0, parity: r[0],
			zero: (r == '0)};
		if (op == ADD) begin
			f.carry = ({1'b0, a} + {1'b0, b}) > {1'b0, {DATA_WIDTH{1'b1}}};
			f.overflow = (sa + sb > smax) || (sa + sb < -smax - 1);
		end else if (op == SUB) begin
			f.carry = a < b;
			f.overflow = (sa - sb > smax) || (sa - sb < -smax - 1);
		end else if (op == MUL) begin
			f.carry = prod[DATA_WIDTH];
			f.overflow = prod[DATA_WIDTH] ^ prod[DATA_WIDTH-1];
		end
		return f;
	endfunction

	task automatic add_entry(string name, exec_op_e op, logic [31:0] s0, logic [31:0] s1,
			logic fwb, logic inv);
		entry_t e;
		e.name = name;
		e.op = op;
		e.src0 = DATA_WIDTH'(s0);
		e.src1 = DATA_WIDTH'(s1);
		e.dest = REG_ADDR_W'(tbl.size());
		e.wb = (tbl.size() % 3) != 0;
		e.flags_wb = fwb;
		e.invalid = inv;
		tbl.push_back(e);
	endtask

	task automatic check_word(string name, logic [DATA_WIDTH-1:0] expected,
			logic [DATA_WIDTH-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
			mismatches++;
		end
	endtask

	task automatic check_flags(string name, exec_flags_t expected, exec_flags_t actual);
		if (actual !== expected) begin
			$display("mismatch %s flags: expected %b, actual %b", name, expected, actual);
			mismatches++;
		end
	endtask

	task automatic check_fault(string name, exec_fault_e expected, exec_fault_e actual);
		if (actual !== expected) begin
			$display("mismatch %s fault_num: expected %0d, actual %0d",
				name, expected, actual);
			mismatches++;
		end
	endtask

	task automatic report(string msg);
		$display("%s", msg);
		failures++;
	endtask

	task automatic drive_entry(int idx);
		in_valid = 1'b1;
		in_op = tbl[idx].op;
		in_src0 = tbl[idx].src0;
		in_src1 = tbl[idx].src1;
		in_dest = tbl[idx].dest;
		in_writeback = tbl[idx].wb;
		in_flags_writeback = tbl[idx].flags_wb;
		in_invalid = tbl[idx].invalid;
		in_pc = pc_of(idx);
	endtask

	task automatic check_output(int idx);
		entry_t e;
		logic [DATA_WIDTH-1:0] res;
		e = tbl[idx];
		res = expect_result(e.op, e.src0, e.src1);
		if (e.flags_wb && !divide_op(e.op))
			exp_flags = expect_flags(e.op, e.src0, e.src1, res);
		check_word({e.name, " data"}, res, out_data);
		check_word({e.name, " dest"}, DATA_WIDTH'(e.dest), DATA_WIDTH'(out_dest));
		check_word({e.name, " writeback"}, DATA_WIDTH'(e.wb), DATA_WIDTH'(out_writeback));
		check_word({e.name, " pc"}, pc_of(idx), out_pc);
		check_flags(e.name, exp_flags, flags);
	endtask

	task automatic run_entry(int idx);
		entry_t e;
		logic want_fault;
		int cycles;
		e = tbl[idx];
		want_fault = e.invalid || (divide_op(e.op) && e.src1 == '0);
		cycles = 0;
		while (issue_lock && cycles < MAX_WAIT) begin
			@(posedge iCLOCK);
			#10;
			cycles++;
		end
		if (issue_lock) begin
			$display("timeout: issue_lock never dropped before test %s", e.name);
			timeouts++;
			return;
		end
		drive_entry(idx);
		@(posedge iCLOCK);
		#10;
		in_valid = 1'b0;
		cycles = 0;
		while (!out_valid && !fault_valid && cycles < MAX_WAIT) begin
			if (!issue_lock)
				report({"issue_lock low while divide pending in test ", e.name});
			@(posedge iCLOCK);
			#10;
			cycles++;
		end
		if (!out_valid && !fault_valid) begin
			$display("timeout: no result or fault for test %s", e.name);
			timeouts++;
		end else if (want_fault != fault_valid) begin
			report({"wrong kind of response (result or fault) in test ", e.name});
		end else if (want_fault) begin
			check_fault(e.name, e.invalid ? FAULT_INVALID_INST : FAULT_DIVIDE_ERROR, fault_num);
			check_word({e.name, " fault_pc"}, pc_of(idx) - DATA_WIDTH'(PC_STEP), fault_pc);
			// Stage must stay locked until refresh
			repeat (2) begin
				@(posedge iCLOCK);
				#10;
				if (!issue_lock)
					report({"issue_lock dropped before refresh after test ", e.name});
			end
			refresh = 1'b1;
			@(posedge iCLOCK);
			#10;
			refresh = 1'b0;
			if (issue_lock || fault_valid)
				report({"refresh did not clear the fault after test ", e.name});
		end else begin
			if (!divide_op(e.op) && cycles != 0)
				report({"out_valid not one cycle after acceptance in test ", e.name});
			check_output(idx);
		end
	endtask

	// Consecutive ALU ops, one accepted per cycle
	task automatic run_burst();
		int sel[$];
		foreach (tbl[i])
			if (!tbl[i].invalid && !divide_op(tbl[i].op))
				sel.push_back(i);
		foreach (sel[k]) begin
			drive_entry(sel[k]);
			@(posedge iCLOCK);
			#10;
			if (!out_valid)
				report({"no out_valid in back-to-back run for test ", tbl[sel[k]].name});
			check_output(sel[k]);
		end
		in_valid = 1'b0;
	endtask

	initial begin
		wait (table_ready);
		#(tbl.size() * MAX_WAIT * 100);
		$display("watchdog: run did not finish in time");
		$display("Something failed");
		$finish;
	end

	initial begin
		logic [31:0] r0;
		logic [31:0] r1;
		exec_op_e rop;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		refresh = 1'b0;
		in_valid = 1'b0;
		in_op = AND;
		in_invalid = 1'b0;
		in_src0 = '0;
		in_src1 = '0;
		in_dest = '0;
		in_writeback = 1'b0;
		in_flags_writeback = 1'b0;
		in_pc = '0;
		exp_flags = '0;

		add_entry("and", AND, 32'hff00ff00, 32'h0f0f0f0f, 1, 0);
		add_entry("or", OR, 32'hf0000000, 32'h0000000f, 1, 0);
		add_entry("xor", XOR, 32'hffff0000, 32'hffff0000, 1, 0);
		add_entry("not", NOT, 32'h12345678, 32'h0, 1, 0);
		add_entry("shl", SHL, 32'h80000001, 32'd4, 1, 0);
		add_entry("shr_wrap", SHR, 32'h80000010, 32'd36, 1, 0);
		add_entry("sar", SAR, 32'h80000010, 32'd4, 1, 0);
		add_entry("rol", ROL, 32'h80000001, 32'd1, 1, 0);
		add_entry("ror", ROR, 32'h00000001, 32'd1, 1, 0);
		add_entry("rol_zero", ROL, 32'hdeadbeef, 32'd0, 1, 0);
		add_entry("add_carry", ADD, 32'hffffffff, 32'd1, 1, 0);
		add_entry("add_ovf", ADD, 32'h7fffffff, 32'd1, 1, 0);
		add_entry("sub_borrow", SUB, 32'd0, 32'd1, 1, 0);
		add_entry("sub_ovf", SUB, 32'h80000000, 32'd1, 1, 0);
		add_entry("add_no_flags", ADD, 32'h7fffffff, 32'h7fffffff, 0, 0);
		add_entry("mul_carry", MUL, 32'h00010000, 32'h00010000, 1, 0);
		add_entry("mul_neg", MUL, 32'hffffffff, 32'd2, 1, 0);
		add_entry("mulh", MULH, 32'h12345678, 32'h9abcdef0, 1, 0);
		add_entry("udiv", UDIV, 32'd100, 32'd7, 1, 0);
		add_entry("sdiv_neg_dividend", SDIV, -32'sd100, 32'd7, 1, 0);
		add_entry("sdiv_neg_divisor", SDIV, 32'd100, -32'sd7, 1, 0);
		add_entry("umod", UMOD, 32'hfffffff0, 32'd9, 1, 0);
		add_entry("smod_neg_dividend", SMOD, -32'sd100, 32'd7, 1, 0);
		add_entry("smod_neg_divisor", SMOD, 32'd100, -32'sd7, 1, 0);
		add_entry("div_by_zero", UDIV, 32'd55, 32'd0, 1, 0);
		add_entry("invalid", ADD, 32'd1, 32'd2, 1, 1);
		add_entry("invalid_and_zero", SDIV, 32'd9, 32'd0, 1, 1);
		add_entry("after_fault", ADD, 32'd40, 32'd2, 1, 0);
		for (int i = 0; i < 16; i++) begin
			r0 = xorshift32();
			r1 = xorshift32();
			rop = exec_op_e'(xorshift32() % 17);
			if (divide_op(rop) && DATA_WIDTH'(r1) == '0)
				r1 = 32'd1;
			add_entry($sformatf("rand_%0d", i), rop, r0, r1, r0[0], 0);
		end
		table_ready = 1'b1;

		repeat (10) @(posedge iCLOCK);
		#10;
		inRESET = 1'b1;
		if (out_valid || fault_valid || issue_lock)
			report("outputs not idle after reset");
		check_flags("reset", '0, flags);

		foreach (tbl[i])
			run_entry(i);
		run_burst();

		$display("errors: %0d mismatches, %0d other failures, %0d timeouts",
			mismatches, failures, timeouts);
		if (mismatches + failures + timeouts == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule
